/* flist.f */
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/result_unit.sv
rtl/cpu_top.sv
tb/cpu_props.sv
tb/tb_top.sv

/* Makefile */
# Verilator build and run for the four-stage pipeline testbench

TOP := tb_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tb/cpu_stim.mem */
// Word 0 program length, then program words from 0x30000000, then record count
// Records: test id, commit pc, commit rd, commit data, exit flag (1 = ebreak, data is a0)
0000001C
00500093 FFD00113 123451B7 00000013
00208233 402082B3 00112333 00000000
0011E3B3 0033C433 01040493 00100513
005485B3 00A5F633 00A60463 06300693
00109463 00700693 00069663 00100713
00100793 00C000EF 00100813 00100893
00408913 02A00513 00100073 00100993
00000015
00000001 30000000 00000001 00000005 00000000
00000001 30000004 00000002 FFFFFFFD 00000000
00000001 30000008 00000003 12345000 00000000
00000001 3000000C 00000000 00000000 00000000
00000001 30000010 00000004 00000002 00000000
00000001 30000014 00000005 00000008 00000000
00000001 30000018 00000006 00000001 00000000
00000001 30000020 00000007 12345005 00000000
00000002 30000024 00000008 00000005 00000000
00000002 30000028 00000009 00000015 00000000
00000002 3000002C 0000000A 00000001 00000000
00000002 30000030 0000000B 0000001D 00000000
00000002 30000034 0000000C 00000001 00000000
00000003 30000038 00000000 00000000 00000000
00000003 30000040 00000000 00000000 00000000
00000003 30000044 0000000D 00000007 00000000
00000003 30000048 00000000 00000000 00000000
00000004 30000054 00000001 30000058 00000000
00000004 30000060 00000012 3000005C 00000000
00000005 30000064 0000000A 0000002A 00000000
00000005 30000068 00000000 0000002A 00000001

/* tb/tb_top.sv */
/*
 * Testbench for the pipeline. Instruction memory with random latency,
 * commit checker against the records in the stimulus file, timeout.
 */

`timescale 1ns/100ps

module tb_top;

    logic               clk;
    logic               rst;
    logic               ifu_req;
    cpu_pkg::word_t     ifu_addr;
    logic               ifu_rvalid;
    cpu_pkg::word_t     ifu_rdata;
    logic               commit_valid;
    cpu_pkg::word_t     commit_pc;
    cpu_pkg::reg_addr_t commit_rd;
    cpu_pkg::word_t     commit_data;
    logic               ebreak_flag;
    cpu_pkg::word_t     exit_code;

    logic [31:0] stim [0:255];
    int          prog_len;
    int          rec_count;
    int          rec_idx;
    int          errors;
    int          checks;
    int          tests_ok;
    int          tests_bad;
    int          test_err_base;
    int          cycles;
    int          limit;
    logic [7:0]  lfsr;
    logic        pending;
    int          wait_cnt;
    cpu_pkg::word_t req_addr;

    cpu_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .ifu_req      (ifu_req),
        .ifu_addr     (ifu_addr),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rdata    (ifu_rdata),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .ebreak_flag  (ebreak_flag),
        .exit_code    (exit_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return (s >> 1) ^ (s[0] ? 8'hB8 : 8'h00);
    endfunction

    function automatic int rec_word(input int idx, input int field);
        return prog_len + 2 + idx * 5 + field;
    endfunction

    function automatic cpu_pkg::word_t program_word(input cpu_pkg::word_t addr);
        cpu_pkg::word_t offs;
        offs = (addr - cpu_pkg::RESET_PC) >> 2;
        if (offs < prog_len) return stim[1 + offs];
        return cpu_pkg::NOP_INST;
    endfunction

    task automatic check_commit(input cpu_pkg::word_t pc, input cpu_pkg::reg_addr_t rd,
                                input cpu_pkg::word_t data);
        checks++;
        if (commit_pc !== pc) begin
            $display("FAILED commit_pc expected %h got %h", pc, commit_pc);
            errors++;
        end
        if (commit_rd !== rd) begin
            $display("FAILED commit_rd expected %h got %h", rd, commit_rd);
            errors++;
        end
        if (commit_data !== data) begin
            $display("FAILED commit_data expected %h got %h at pc %h", data, commit_data, pc);
            errors++;
        end
    endtask

    task automatic check_exit(input cpu_pkg::word_t code);
        checks++;
        if (ebreak_flag !== 1'b1) begin
            $display("ebreak committed but ebreak_flag is not set");
            errors++;
        end else if (exit_code !== code) begin
            $display("FAILED exit_code expected %h got %h", code, exit_code);
            errors++;
        end
    endtask

    // Memory model, one response 1 to 4 cycles after each request
    always @(negedge clk) begin
        ifu_rvalid <= 1'b0;
        if (!rst) begin
            if (ifu_req) begin
                pending  = 1'b1;
                req_addr = ifu_addr;
                wait_cnt = 1 + {lfsr[0], 1'b0};
                lfsr     = lfsr_next(lfsr);
                wait_cnt = wait_cnt + lfsr[0];
                lfsr     = lfsr_next(lfsr);
            end
            if (pending) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    ifu_rvalid <= 1'b1;
                    ifu_rdata  <= program_word(req_addr);
                    pending = 1'b0;
                end
            end
        end
    end

    // Commit checker
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (rec_idx >= rec_count) begin
                $display("Unexpected commit at pc %h after all expected records", commit_pc);
                errors++;
            end else begin
                check_commit(stim[rec_word(rec_idx, 1)], stim[rec_word(rec_idx, 2)][4:0],
                             stim[rec_word(rec_idx, 3)]);
                if (stim[rec_word(rec_idx, 4)] != 0) check_exit(stim[rec_word(rec_idx, 3)]);
                // Last record of its test
                if (rec_idx + 1 == rec_count ||
                    stim[rec_word(rec_idx + 1, 0)] != stim[rec_word(rec_idx, 0)]) begin
                    if (errors == test_err_base) begin
                        $display("test %0d ok", stim[rec_word(rec_idx, 0)]);
                        tests_ok++;
                    end else begin
                        $display("test %0d had %0d errors", stim[rec_word(rec_idx, 0)],
                                 errors - test_err_base);
                        tests_bad++;
                    end
                    test_err_base = errors;
                end
                rec_idx++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        rst        = 1'b1;
        ifu_rvalid = 1'b0;
        ifu_rdata  = '0;
        lfsr       = 8'd85;
        pending    = 1'b0;
        wait_cnt   = 0;
        req_addr   = '0;
        rec_idx    = 0;
        errors     = 0;
        checks     = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        test_err_base = 0;
        cycles     = 0;
        $readmemh("tb/cpu_stim.mem", stim);
        prog_len  = stim[0];
        rec_count = stim[prog_len + 1];
        limit     = (prog_len + rec_count) * 12 + 200;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Progress is sampled away from the checker's edge
        while (rec_idx < rec_count && cycles < limit) @(posedge clk);
        if (rec_idx < rec_count) begin
            $display("Timeout after %0d cycles with %0d of %0d commits seen",
                     cycles, rec_idx, rec_count);
            errors++;
        end else begin
            // Room for a stray commit after the halt
            repeat (10) @(posedge clk);
        end

        $display("tests ok %0d, tests failing %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/cpu_props.sv */
/*
 * Protocol properties of the pipeline top level.
 * Pulsed fetch requests, quiet commit port after ebreak, known commit_rd.
 */

`timescale 1ns/100ps

module cpu_props (
    input logic               clk,
    input logic               rst,
    input logic               ifu_req,
    input logic               commit_valid,
    input cpu_pkg::reg_addr_t commit_rd,
    input logic               ebreak_flag
);

    a_req_pulse : assert property (@(posedge clk) disable iff (rst)
        ifu_req |=> !ifu_req)
        else $error("ifu_req held high for two cycles");

    // The ebreak commit itself comes with the flag, nothing may follow
    a_no_commit_after_halt : assert property (@(posedge clk) disable iff (rst)
        ebreak_flag |=> !commit_valid)
        else $error("commit after ebreak_flag was set");

    a_commit_rd_known : assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> !$isunknown(commit_rd))
        else $error("commit_rd unknown during commit");

endmodule

bind cpu_top cpu_props props_i (
    .clk          (clk),
    .rst          (rst),
    .ifu_req      (ifu_req),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .ebreak_flag  (ebreak_flag)
);

/* rtl/cpu_top.sv */
/*
 * Top level of the four-stage pipeline.
 * Fetch, decode, execute and result joined by interfaces and wires.
 */

`timescale 1ns/100ps

module cpu_top (
    input  logic               clk,
    input  logic               rst,
    output logic               ifu_req,
    output cpu_pkg::word_t     ifu_addr,
    input  logic               ifu_rvalid,
    input  cpu_pkg::word_t     ifu_rdata,
    output logic               commit_valid,
    output cpu_pkg::word_t     commit_pc,
    output cpu_pkg::reg_addr_t commit_rd,
    output cpu_pkg::word_t     commit_data,
    output logic               ebreak_flag,
    output cpu_pkg::word_t     exit_code
);

    fetch_dec_if fd_if ();
    dec_ex_if    de_if ();

    logic               redirect;
    cpu_pkg::word_t     redirect_pc;
    cpu_pkg::bypass_t   ex_bypass;
    cpu_pkg::op_e       ex_op;
    cpu_pkg::word_t     ex_pc;
    logic               wb_en;
    cpu_pkg::reg_addr_t wb_rd;
    cpu_pkg::word_t     wb_data;
    logic               halted;

    fetch_unit fetch_i (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted),
        .ifu_req     (ifu_req),
        .ifu_addr    (ifu_addr),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rdata   (ifu_rdata),
        .fd          (fd_if.fetch)
    );

    decode_unit decode_i (
        .clk       (clk),
        .rst       (rst),
        .fd        (fd_if.decode),
        .de        (de_if.decode),
        .redirect  (redirect),
        .ex_bypass (ex_bypass),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    execute_unit execute_i (
        .clk         (clk),
        .rst         (rst),
        .de          (de_if.execute),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_bypass   (ex_bypass),
        .ex_op       (ex_op),
        .ex_pc       (ex_pc)
    );

    result_unit result_i (
        .clk          (clk),
        .rst          (rst),
        .ex_bypass    (ex_bypass),
        .ex_op        (ex_op),
        .ex_pc        (ex_pc),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .ebreak_flag  (ebreak_flag),
        .exit_code    (exit_code),
        .halted       (halted)
    );

endmodule

/* rtl/result_unit.sv */
/*
 * Result stage. Registers the write-back and the commit record,
 * and latches the halt with a0 as exit code on ebreak.
 */

`timescale 1ns/100ps

module result_unit (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::bypass_t   ex_bypass,
    input  cpu_pkg::op_e       ex_op,
    input  cpu_pkg::word_t     ex_pc,
    output logic               wb_en,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::word_t     wb_data,
    output logic               commit_valid,
    output cpu_pkg::word_t     commit_pc,
    output cpu_pkg::reg_addr_t commit_rd,
    output cpu_pkg::word_t     commit_data,
    output logic               ebreak_flag,
    output cpu_pkg::word_t     exit_code,
    output logic               halted
);

    logic no_write;
    logic is_ebreak;

    assign no_write  = ex_op == cpu_pkg::op_beq || ex_op == cpu_pkg::op_bne ||
                       ex_op == cpu_pkg::op_ebreak;
    assign is_ebreak = ex_bypass.valid && ex_op == cpu_pkg::op_ebreak;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en        <= 1'b0;
            commit_valid <= 1'b0;
            ebreak_flag  <= 1'b0;
            exit_code    <= '0;
        end else begin
            wb_en        <= ex_bypass.valid && !no_write && ex_bypass.rd != '0;
            // Undecodable words retire silently
            commit_valid <= ex_bypass.valid && ex_op != cpu_pkg::op_nop;
            if (is_ebreak) begin
                ebreak_flag <= 1'b1;
                exit_code   <= ex_bypass.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= ex_bypass.rd;
        wb_data     <= ex_bypass.data;
        commit_pc   <= ex_pc;
        commit_rd   <= ex_bypass.rd;
        // Data of an x0 write reads back as zero
        commit_data <= (ex_bypass.rd == '0 && ex_op != cpu_pkg::op_ebreak) ? '0 :
                       ex_bypass.data;
    end

    assign halted = ebreak_flag;

endmodule

/* rtl/execute_unit.sv */
/*
 * Execute stage. ALU, branch compare and jump target, redirect of
 * fetch on a taken branch or jal, and the execute/result register.
 */

`timescale 1ns/100ps

module execute_unit (
    input  logic             clk,
    input  logic             rst,
    dec_ex_if.execute        de,
    output logic             redirect,
    output cpu_pkg::word_t   redirect_pc,
    output cpu_pkg::bypass_t ex_bypass,
    output cpu_pkg::op_e     ex_op,
    output cpu_pkg::word_t   ex_pc
);

    cpu_pkg::word_t     alu_res;
    logic               taken;
    logic               ex_valid;
    cpu_pkg::reg_addr_t ex_rd;
    cpu_pkg::word_t     ex_data;

    always_comb begin
        alu_res = '0;
        taken   = 1'b0;
        case (de.op)
            cpu_pkg::op_add:  alu_res = de.a + de.b;
            cpu_pkg::op_sub:  alu_res = de.a - de.b;
            cpu_pkg::op_and:  alu_res = de.a & de.b;
            cpu_pkg::op_or:   alu_res = de.a | de.b;
            cpu_pkg::op_xor:  alu_res = de.a ^ de.b;
            cpu_pkg::op_slt:  alu_res = {31'b0, $signed(de.a) < $signed(de.b)};
            cpu_pkg::op_addi: alu_res = de.a + de.imm;
            cpu_pkg::op_lui:  alu_res = de.imm;
            cpu_pkg::op_beq:  taken = (de.a == de.b);
            cpu_pkg::op_bne:  taken = (de.a != de.b);
            cpu_pkg::op_jal: begin
                // Link value
                alu_res = de.pc + 32'd4;
                taken   = 1'b1;
            end
            // Exit code travels as the result
            cpu_pkg::op_ebreak: alu_res = de.a;
            default: alu_res = '0;
        endcase
    end

    // Branch and jal targets are both pc relative
    assign redirect    = de.valid && taken;
    assign redirect_pc = de.pc + de.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_op    <= cpu_pkg::op_nop;
        end else begin
            ex_valid <= de.valid;
            ex_op    <= de.valid ? de.op : cpu_pkg::op_nop;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd   <= de.rd;
        ex_data <= alu_res;
        ex_pc   <= de.pc;
    end

    assign ex_bypass = '{valid: ex_valid, rd: ex_rd, data: ex_data};

endmodule

/* rtl/decode_unit.sv */
/*
 * Decode stage. Maps the instruction to an operation and immediate,
 * reads and forwards operands, stalls on a dependence on the
 * instruction in execute, and loads the decode/execute register.
 */

`timescale 1ns/100ps

module decode_unit (
    input  logic               clk,
    input  logic               rst,
    fetch_dec_if.decode        fd,
    dec_ex_if.decode           de,
    input  logic               redirect,
    input  cpu_pkg::bypass_t   ex_bypass,
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t     wb_data,
    input  logic               halted
);

    cpu_pkg::word_t     inst;
    cpu_pkg::op_e       op;
    cpu_pkg::word_t     imm;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rd;
    logic               use_rs1;
    logic               use_rs2;
    cpu_pkg::word_t     rf_rd1;
    cpu_pkg::word_t     rf_rd2;
    logic               stall;
    logic               ebreak_seen;

    // An empty slot decodes as a nop and matches no register
    assign inst = fd.valid ? fd.inst : cpu_pkg::NOP_INST;

    always_comb begin
        op      = cpu_pkg::op_nop;
        imm     = {{20{inst[31]}}, inst[31:20]};
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (inst[6:0])
            7'b0110011: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (inst[31:25] == 7'b0000000) begin
                    case (inst[14:12])
                        3'b000: op = cpu_pkg::op_add;
                        3'b111: op = cpu_pkg::op_and;
                        3'b110: op = cpu_pkg::op_or;
                        3'b100: op = cpu_pkg::op_xor;
                        3'b010: op = cpu_pkg::op_slt;
                        default: op = cpu_pkg::op_nop;
                    endcase
                end else if (inst[31:25] == 7'b0100000 && inst[14:12] == 3'b000) begin
                    op = cpu_pkg::op_sub;
                end
            end
            7'b0010011: begin
                use_rs1 = 1'b1;
                if (inst[14:12] == 3'b000) op = cpu_pkg::op_addi;
            end
            7'b0110111: begin
                op  = cpu_pkg::op_lui;
                imm = {inst[31:12], 12'b0};
            end
            7'b1100011: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                if (inst[14:12] == 3'b000) op = cpu_pkg::op_beq;
                if (inst[14:12] == 3'b001) op = cpu_pkg::op_bne;
            end
            7'b1101111: begin
                op  = cpu_pkg::op_jal;
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'b1110011: begin
                // ebreak reads a0 for the exit code
                if (inst == 32'h0010_0073) begin
                    op      = cpu_pkg::op_ebreak;
                    use_rs1 = 1'b1;
                end
            end
            default: op = cpu_pkg::op_nop;
        endcase
        if (op == cpu_pkg::op_nop) begin
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    assign rs1 = (op == cpu_pkg::op_ebreak) ? 5'd10 : inst[19:15];

    // Only ALU ops, lui and jal write a register
    assign rd = (op == cpu_pkg::op_nop || op == cpu_pkg::op_beq || op == cpu_pkg::op_bne ||
                 op == cpu_pkg::op_ebreak) ? '0 : inst[11:7];

    reg_file rf_i (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (inst[24:20]),
        .rd1     (rf_rd1),
        .rd2     (rf_rd2),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    // Execute result is one cycle short of being forwardable
    assign stall = de.valid && de.rd != '0 &&
                   ((use_rs1 && rs1 == de.rd) || (use_rs2 && inst[24:20] == de.rd));

    assign fd.take = fd.valid && !stall && !redirect && !ebreak_seen && !halted;

    function automatic cpu_pkg::word_t fwd(input cpu_pkg::reg_addr_t rs,
                                           input cpu_pkg::word_t rf_val);
        if (ex_bypass.valid && ex_bypass.rd == rs && rs != '0) return ex_bypass.data;
        return rf_val;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de.valid    <= 1'b0;
            de.op       <= cpu_pkg::op_nop;
            ebreak_seen <= 1'b0;
        end else begin
            // Bubble on stall, redirect or empty slot
            de.valid <= fd.take;
            de.op    <= fd.take ? op : cpu_pkg::op_nop;
            if (fd.take && op == cpu_pkg::op_ebreak) ebreak_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fd.take) begin
            de.pc  <= fd.pc;
            de.rd  <= rd;
            de.a   <= fwd(rs1, rf_rd1);
            de.b   <= fwd(inst[24:20], rf_rd2);
            de.imm <= imm;
        end
    end

endmodule

/* rtl/reg_file.sv */
/*
 * Integer register file, 31 writable entries plus hard-wired x0.
 * Reads see a same-cycle write.
 */

`timescale 1ns/100ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::word_t     rd1,
    output cpu_pkg::word_t     rd2,
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t     wb_data
);

    cpu_pkg::word_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

/* rtl/fetch_unit.sv */
/*
 * Instruction fetch. Issues one pulsed request at a time, captures
 * the response into the holding register read by decode, and drops
 * a response that was already in flight when a redirect came in.
 */

`timescale 1ns/100ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect,
    input  cpu_pkg::word_t        redirect_pc,
    input  logic                  halted,
    output logic                  ifu_req,
    output cpu_pkg::word_t        ifu_addr,
    input  logic                  ifu_rvalid,
    input  cpu_pkg::word_t        ifu_rdata,
    fetch_dec_if.fetch            fd
);

    cpu_pkg::fetch_state_e state;
    cpu_pkg::word_t        pc;
    logic                  issue;
    logic                  capture;

    // Room in the holding register and nothing outstanding
    assign issue = (state == cpu_pkg::fs_idle) && (!fd.valid || fd.take) &&
                   !halted && !redirect;

    assign capture = (state == cpu_pkg::fs_wait) && ifu_rvalid && !redirect;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= cpu_pkg::fs_idle;
            pc       <= cpu_pkg::RESET_PC;
            ifu_req  <= 1'b0;
            fd.valid <= 1'b0;
        end else begin
            ifu_req <= issue;

            case (state)
                cpu_pkg::fs_idle: begin
                    if (issue) state <= cpu_pkg::fs_wait;
                end
                cpu_pkg::fs_wait: begin
                    if (ifu_rvalid) begin
                        state <= cpu_pkg::fs_idle;
                    end else if (redirect) begin
                        state <= cpu_pkg::fs_discard;
                    end
                end
                cpu_pkg::fs_discard: begin
                    // Stale response, thrown away
                    if (ifu_rvalid) state <= cpu_pkg::fs_idle;
                end
                default: state <= cpu_pkg::fs_idle;
            endcase

            if (redirect) begin
                pc <= redirect_pc;
            end else if (issue) begin
                pc <= pc + 32'd4;
            end

            if (redirect) begin
                fd.valid <= 1'b0;
            end else if (capture) begin
                fd.valid <= 1'b1;
            end else if (fd.take) begin
                fd.valid <= 1'b0;
            end
        end
    end

    // Address held steady until the response comes back
    always_ff @(posedge clk) begin
        if (issue) ifu_addr <= pc;
        if (capture) begin
            fd.pc   <= ifu_addr;
            fd.inst <= ifu_rdata;
        end
    end

endmodule

/* rtl/pipe_if.sv */
/*
 * Stage-to-stage bundles of the pipeline.
 * fetch_dec_if is a valid/take handshake, dec_ex_if has no back-pressure.
 */

`timescale 1ns/100ps

interface fetch_dec_if;
    logic           valid;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t inst;
    logic           take;

    modport fetch (
        output valid,
        output pc,
        output inst,
        input  take
    );

    modport decode (
        input  valid,
        input  pc,
        input  inst,
        output take
    );
endinterface

interface dec_ex_if;
    logic               valid;
    cpu_pkg::word_t     pc;
    cpu_pkg::op_e       op;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     a;
    cpu_pkg::word_t     b;
    cpu_pkg::word_t     imm;

    modport decode (
        output valid,
        output pc,
        output op,
        output rd,
        output a,
        output b,
        output imm
    );

    modport execute (
        input valid,
        input pc,
        input op,
        input rd,
        input a,
        input b,
        input imm
    );
endinterface

/* rtl/cpu_pkg.sv */
/*
 * Shared definitions for the four-stage RV32I subset pipeline.
 * Widths, reset PC, operation and fetch state encodings, bypass record.
 */

package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // First fetch address after reset
    localparam word_t RESET_PC = 32'h3000_0000;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_addi,
        op_lui,
        op_beq,
        op_bne,
        op_jal,
        op_ebreak
    } op_e;

    typedef enum logic [1:0] {
        fs_idle,
        fs_wait,
        fs_discard
    } fetch_state_e;

    // Result still on its way to the register file
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } bypass_t;

endpackage
